/* sources.f */
rtl/TrigTestPkg.sv
rtl/TrigTestConfig.sv
rtl/SCurveSingleInput.sv
rtl/TrigEfficiencyTest.sv
rtl/TrigEfficiencyTop.sv
tb/TrigEfficiencyTb.sv

/* tb/TrigEfficiencyTb.sv */
`timescale 1ns/1ps

module TrigEfficiencyTb
    import TrigTestPkg::*;
();

    localparam int HalfPeriod = 4;
    localparam int NumRuns = 7;
    localparam logic [31:0] Seed = 32'h9388_8022;

    logic    Clk = 1'b0;
    logic    reset_n;
    logic    CfgWrite;
    cfgAddrT CfgAddr;
    wordT    CfgWriteData;
    logic    ExtPulse;
    logic    TriggerB0;
    logic    TriggerB1;
    logic    TriggerB2;
    logic    DataTransmitDone;
    wordT    FrameData;
    logic    FrameDataEn;
    logic    TestDone;

    wordT  frameQ [$];
    countT cptPlan [NumRuns];
    delayT delayPlan [NumRuns];
    int    errorCount = 0;
    int    passCount = 0;
    int    failCount = 0;
    int    watchdogCycles = 0;
    int    errorsBefore;

    always #HalfPeriod Clk = ~Clk;

    TrigEfficiencyTop TrigEfficiencyTop_inst (
        .Clk              (Clk),
        .reset_n          (reset_n),
        .CfgWrite         (CfgWrite),
        .CfgAddr          (CfgAddr),
        .CfgWriteData     (CfgWriteData),
        .ExtPulse         (ExtPulse),
        .TriggerB0        (TriggerB0),
        .TriggerB1        (TriggerB1),
        .TriggerB2        (TriggerB2),
        .DataTransmitDone (DataTransmitDone),
        .FrameData        (FrameData),
        .FrameDataEn      (FrameDataEn),
        .TestDone         (TestDone)
    );

    // Frame collector
    always @(negedge Clk) begin
        if (reset_n && FrameDataEn) begin
            frameQ.push_back(FrameData);
        end
    end

    ////////////////////
    // Compare tasks

    task automatic checkWord(input string name, input wordT actual, input wordT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic checkCount(input string name, input countT actual, input countT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic checkLevel(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic reportTest(input string name);
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("%s: passed", name);
        end else begin
            failCount++;
            $display("%s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    ////////////////////
    // Stimulus

    task automatic writeReg(input cfgAddrT addr, input wordT data);
        @(posedge Clk);
        CfgWrite     <= 1'b1;
        CfgAddr      <= addr;
        CfgWriteData <= data;
        @(posedge Clk);
        CfgWrite <= 1'b0;
    endtask

    // One full run from configuration to the frame check
    task automatic doRun(input countT cptMax, input delayT trigDelay, input int pct0,
                         input int pct1, input int pct2);
        int    firePct [NumChannels];
        int    offset [NumChannels];
        logic  fire [NumChannels];
        logic  [NumChannels-1:0] trigVec;
        countT expTrig [NumChannels];
        wordT  expFrame [FrameWords+1];
        int    gap;
        int    ackDelay;
        firePct[0] = pct0;
        firePct[1] = pct1;
        firePct[2] = pct2;
        for (int c = 0; c < NumChannels; c++) begin
            expTrig[c] = '0;
        end
        frameQ.delete();
        writeReg(CfgAddrCptMax, wordT'(cptMax));
        writeReg(CfgAddrDelay, wordT'(trigDelay));
        writeReg(CfgAddrControl, 16'h0001);
        // Counters are armed a few cycles after the header word
        while (frameQ.size() == 0) @(negedge Clk);
        repeat (10) @(posedge Clk);
        for (int p = 0; p < int'(cptMax); p++) begin
            for (int c = 0; c < NumChannels; c++) begin
                fire[c]   = ($urandom % 100) < firePct[c];
                offset[c] = 1 + $urandom % ((trigDelay == 0) ? 1 : int'(trigDelay));
                if (fire[c]) expTrig[c]++;
            end
            gap = 40 + $urandom % 20;
            for (int k = 0; k < 4 + gap; k++) begin
                for (int c = 0; c < NumChannels; c++) begin
                    trigVec[c] = !(fire[c] && k >= offset[c] && k < offset[c] + 2);
                end
                ExtPulse  <= (k < 4);
                TriggerB0 <= trigVec[0];
                TriggerB1 <= trigVec[1];
                TriggerB2 <= trigVec[2];
                @(posedge Clk);
            end
        end
        while (!TestDone) @(negedge Clk);
        ackDelay = 3 + $urandom % 18;
        repeat (ackDelay) begin
            @(negedge Clk);
            checkLevel("TestDone", TestDone, 1'b1);
        end
        @(posedge Clk);
        DataTransmitDone <= 1'b1;
        @(posedge Clk);
        DataTransmitDone <= 1'b0;
        @(negedge Clk);
        checkLevel("TestDone", TestDone, 1'b0);
        expFrame[0] = FrameHeader;
        for (int c = 0; c < NumChannels; c++) begin
            expFrame[1 + 2*c] = wordT'(cptMax);
            expFrame[2 + 2*c] = wordT'(expTrig[c]);
        end
        checkCount("frame length", countT'(frameQ.size()), countT'(FrameWords + 1));
        for (int i = 0; i < FrameWords + 1 && i < frameQ.size(); i++) begin
            checkWord($sformatf("FrameData[%0d]", i), frameQ[i], expFrame[i]);
        end
    endtask

    ////////////////////
    // Watchdog

    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge Clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
        $display("Test failed");
        $finish;
    end

    ////////////////////
    // Main sequence

    initial begin
        void'($urandom(Seed));
        reset_n          = 1'b0;
        CfgWrite         = 1'b0;
        CfgAddr          = '0;
        CfgWriteData     = '0;
        ExtPulse         = 1'b0;
        TriggerB0        = 1'b1;
        TriggerB1        = 1'b1;
        TriggerB2        = 1'b1;
        DataTransmitDone = 1'b0;
        cptPlan[0] = 20;
        delayPlan[0] = 7;
        for (int r = 1; r < 4; r++) begin
            cptPlan[r]   = countT'(5 + $urandom % 36);
            delayPlan[r] = delayT'($urandom % 16);
        end
        cptPlan[4] = 0;
        delayPlan[4] = 3;
        cptPlan[5] = countT'(5 + $urandom % 21);
        delayPlan[5] = 2;
        cptPlan[6] = countT'(5 + $urandom % 21);
        delayPlan[6] = 12;
        for (int r = 0; r < NumRuns; r++) watchdogCycles += int'(cptPlan[r]) * 80 + 400;
        watchdogCycles += 1000;
        repeat (5) @(posedge Clk);
        reset_n <= 1'b1;

        errorsBefore = errorCount;
        @(negedge Clk);
        checkLevel("TestDone", TestDone, 1'b0);
        repeat (50) begin
            @(negedge Clk);
            checkLevel("FrameDataEn", FrameDataEn, 1'b0);
        end
        checkCount("frame words without start", countT'(frameQ.size()), '0);
        reportTest("Check 1 idle after reset");

        errorsBefore = errorCount;
        doRun(cptPlan[0], delayPlan[0], 100, 100, 100);
        reportTest("Check 2 all triggers firing");

        errorsBefore = errorCount;
        for (int r = 1; r < 4; r++) begin
            doRun(cptPlan[r], delayPlan[r], 10 + $urandom % 81, 10 + $urandom % 81,
                  10 + $urandom % 81);
        end
        reportTest("Check 3 random firing");

        errorsBefore = errorCount;
        doRun(cptPlan[4], delayPlan[4], 100, 100, 100);
        reportTest("Check 4 zero pulse count");

        errorsBefore = errorCount;
        doRun(cptPlan[5], delayPlan[5], 70, 40, 90);
        // Start was cleared, so the sequencer must stay quiet
        repeat (40) begin
            @(negedge Clk);
            checkLevel("FrameDataEn", FrameDataEn, 1'b0);
            checkLevel("TestDone", TestDone, 1'b0);
        end
        checkCount("frame words after run", countT'(frameQ.size()), countT'(FrameWords + 1));
        doRun(cptPlan[6], delayPlan[6], 30, 60, 80);
        reportTest("Check 5 back to back runs");

        $display("Summary: %0d passed, %0d failing, %0d mismatches", passCount, failCount,
                 errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* rtl/TrigEfficiencyTop.sv */
`timescale 1ns/1ps

module TrigEfficiencyTop
    import TrigTestPkg::*;
(
    input  logic    Clk,
    input  logic    reset_n,
    input  logic    CfgWrite,
    input  cfgAddrT CfgAddr,
    input  wordT    CfgWriteData,
    input  logic    ExtPulse,
    input  logic    TriggerB0,
    input  logic    TriggerB1,
    input  logic    TriggerB2,
    input  logic    DataTransmitDone,
    output wordT    FrameData,
    output logic    FrameDataEn,
    output logic    TestDone
);

    countT cptMax;
    delayT triggerDelay;
    logic  start;

    // Software visible registers
    TrigTestConfig TrigTestConfig_inst (
        .Clk          (Clk),
        .reset_n      (reset_n),
        .CfgWrite     (CfgWrite),
        .CfgAddr      (CfgAddr),
        .CfgWriteData (CfgWriteData),
        .TestDone     (TestDone),
        .CptMax       (cptMax),
        .TriggerDelay (triggerDelay),
        .Start        (start)
    );

    // Sequencer with the three channel counters
    TrigEfficiencyTest TrigEfficiencyTest_inst (
        .Clk              (Clk),
        .reset_n          (reset_n),
        .Start            (start),
        .CptMax           (cptMax),
        .TriggerDelay     (triggerDelay),
        .ExtPulse         (ExtPulse),
        .TriggerB0        (TriggerB0),
        .TriggerB1        (TriggerB1),
        .TriggerB2        (TriggerB2),
        .DataTransmitDone (DataTransmitDone),
        .FrameData        (FrameData),
        .FrameDataEn      (FrameDataEn),
        .TestDone         (TestDone)
    );

endmodule

/* rtl/TrigEfficiencyTest.sv */
`timescale 1ns/1ps

module TrigEfficiencyTest
    import TrigTestPkg::*;
(
    input  logic  Clk,
    input  logic  reset_n,
    input  logic  Start,
    input  countT CptMax,
    input  delayT TriggerDelay,
    input  logic  ExtPulse,
    input  logic  TriggerB0,
    input  logic  TriggerB1,
    input  logic  TriggerB2,
    input  logic  DataTransmitDone,
    output wordT  FrameData,
    output logic  FrameDataEn,
    output logic  TestDone
);

    logic [NumChannels-1:0]          trigBVec;
    countT                           pulseCount [NumChannels];
    countT                           triggerCount [NumChannels];
    logic [NumChannels-1:0]          countDone;
    logic                            allDone;
    logic                            channelClear;
    logic                            measure;
    testStateT                       state;
    logic [WordCountWidth-1:0]       wordCount;
    logic [FrameWords*WordWidth-1:0] countsFlat;
    logic [FrameWords*WordWidth-1:0] frameShift;

    assign trigBVec = {TriggerB2, TriggerB1, TriggerB0};
    assign allDone  = &countDone;

    ////////////////////
    // Channel counters

    for (genvar ch = 0; ch < NumChannels; ch++) begin : gChannel
        SCurveSingleInput SCurveSingleInput_inst (
            .Clk          (Clk),
            .reset_n      (reset_n),
            .ChannelClear (channelClear),
            .Measure      (measure),
            .ExtPulse     (ExtPulse),
            .TriggerB     (trigBVec[ch]),
            .CptMax       (CptMax),
            .TriggerDelay (TriggerDelay),
            .PulseCount   (pulseCount[ch]),
            .TriggerCount (triggerCount[ch]),
            .CountDone    (countDone[ch])
        );
    end

    // Channel 0 pulse count lands in the top word
    always_comb begin
        for (int ch = 0; ch < NumChannels; ch++) begin
            countsFlat[(FrameWords-1-2*ch)*WordWidth +: WordWidth] = pulseCount[ch];
            countsFlat[(FrameWords-2-2*ch)*WordWidth +: WordWidth] = triggerCount[ch];
        end
    end

    ////////////////////
    // Run sequencer

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= TsIdle;
            FrameDataEn  <= 1'b0;
            TestDone     <= 1'b0;
            channelClear <= 1'b0;
            measure      <= 1'b0;
            wordCount    <= '0;
        end else begin
            // Strobes last one cycle
            FrameDataEn  <= 1'b0;
            channelClear <= 1'b0;

            case (state)
                TsIdle: begin
                    TestDone  <= 1'b0;
                    wordCount <= '0;
                    if (Start) begin
                        channelClear <= 1'b1;
                        state        <= TsHeader;
                    end
                end
                TsHeader: begin
                    FrameDataEn <= 1'b1;
                    state       <= TsLaunch;
                end
                TsLaunch: begin
                    measure <= 1'b1;
                    state   <= TsMeasure;
                end
                TsMeasure: begin
                    if (allDone) begin
                        measure <= 1'b0;
                        state   <= TsCapture;
                    end
                end
                TsCapture: begin
                    state <= TsEmit;
                end
                TsEmit: begin
                    if (wordCount < WordCountWidth'(FrameWords)) begin
                        wordCount <= wordCount + 1'b1;
                        state     <= TsEmitStrobe;
                    end else begin
                        TestDone <= 1'b1;
                        state    <= TsFinished;
                    end
                end
                TsEmitStrobe: begin
                    FrameDataEn <= 1'b1;
                    state       <= TsEmit;
                end
                TsFinished: begin
                    // Hold until the link has taken the frame
                    if (DataTransmitDone) begin
                        TestDone <= 1'b0;
                        state    <= TsIdle;
                    end
                end
                default: begin
                    state <= TsIdle;
                end
            endcase
        end
    end

    ////////////////////
    // Frame data path

    always_ff @(posedge Clk) begin
        case (state)
            TsIdle: begin
                FrameData <= FrameHeader;
            end
            TsCapture: begin
                frameShift <= countsFlat;
            end
            TsEmit: begin
                FrameData <= frameShift[FrameWords*WordWidth-1 -: WordWidth];
            end
            TsEmitStrobe: begin
                frameShift <= frameShift << WordWidth;
            end
            default: begin
            end
        endcase
    end

    ////////////////////
    // Checks

    // The link relies on a gap after every word
    strobeGap: assert property (
        @(posedge Clk) disable iff (!reset_n)
        FrameDataEn |=> !FrameDataEn
    ) else $error("FrameDataEn high on consecutive cycles");

endmodule

/* rtl/SCurveSingleInput.sv */
`timescale 1ns/1ps

module SCurveSingleInput
    import TrigTestPkg::*;
(
    input  logic  Clk,
    input  logic  reset_n,
    input  logic  ChannelClear,
    input  logic  Measure,
    input  logic  ExtPulse,
    input  logic  TriggerB,
    input  countT CptMax,
    input  delayT TriggerDelay,
    output countT PulseCount,
    output countT TriggerCount,
    output logic  CountDone
);

    logic [1:0]  pulseSync;
    logic [1:0]  trigSync;
    logic        pulseDly;
    logic        pulseRise;
    logic        trigLow;
    scurveStateT state;
    delayT       windowCnt;
    logic        hit;

    ////////////////////
    // Input synchronizers

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            pulseSync <= 2'b00;
            // Trigger lines idle high
            trigSync  <= 2'b11;
            pulseDly  <= 1'b0;
        end else begin
            pulseSync <= {pulseSync[0], ExtPulse};
            trigSync  <= {trigSync[0], TriggerB};
            pulseDly  <= pulseSync[1];
        end
    end

    assign pulseRise = pulseSync[1] & ~pulseDly;
    assign trigLow   = ~trigSync[1];

    ////////////////////
    // Window FSM and counters

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= ScIdle;
            PulseCount   <= '0;
            TriggerCount <= '0;
            windowCnt    <= '0;
            hit          <= 1'b0;
        end else if (ChannelClear) begin
            state        <= ScIdle;
            PulseCount   <= '0;
            TriggerCount <= '0;
            windowCnt    <= '0;
            hit          <= 1'b0;
        end else if (!Measure) begin
            // Counts are kept for the sequencer to capture
            state <= ScIdle;
        end else begin
            case (state)
                ScIdle: begin
                    state <= ScArmed;
                end
                ScArmed: begin
                    if (PulseCount >= CptMax) begin
                        state <= ScDone;
                    end else if (pulseRise) begin
                        PulseCount <= PulseCount + 1'b1;
                        windowCnt  <= TriggerDelay;
                        hit        <= 1'b0;
                        state      <= ScWindow;
                    end
                end
                ScWindow: begin
                    // One trigger count per pulse at most
                    if (trigLow && !hit) begin
                        TriggerCount <= TriggerCount + 1'b1;
                        hit          <= 1'b1;
                    end
                    if (windowCnt == '0) begin
                        state <= ScArmed;
                    end else begin
                        windowCnt <= windowCnt - 1'b1;
                    end
                end
                ScDone: begin
                    state <= ScDone;
                end
                default: begin
                    state <= ScIdle;
                end
            endcase
        end
    end

    assign CountDone = (state == ScDone);

    ////////////////////
    // Checks

    pulseWithinMax: assert property (
        @(posedge Clk) disable iff (!reset_n)
        Measure |-> PulseCount <= CptMax
    ) else $error("PulseCount above CptMax");

    triggerWithinPulse: assert property (
        @(posedge Clk) disable iff (!reset_n)
        TriggerCount <= PulseCount
    ) else $error("TriggerCount above PulseCount");

endmodule

/* rtl/TrigTestConfig.sv */
`timescale 1ns/1ps

module TrigTestConfig
    import TrigTestPkg::*;
(
    input  logic    Clk,
    input  logic    reset_n,
    input  logic    CfgWrite,
    input  cfgAddrT CfgAddr,
    input  wordT    CfgWriteData,
    input  logic    TestDone,
    output countT   CptMax,
    output delayT   TriggerDelay,
    output logic    Start
);

    logic testDoneDly;
    logic testDoneRise;

    // End of run seen from the sequencer
    assign testDoneRise = TestDone & ~testDoneDly;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            CptMax       <= '0;
            TriggerDelay <= '0;
            Start        <= 1'b0;
            testDoneDly  <= 1'b0;
        end else begin
            testDoneDly <= TestDone;

            if (CfgWrite) begin
                case (CfgAddr)
                    CfgAddrCptMax: begin
                        CptMax <= countT'(CfgWriteData);
                    end
                    CfgAddrDelay: begin
                        TriggerDelay <= CfgWriteData[DelayWidth-1:0];
                    end
                    CfgAddrControl: begin
                        Start <= CfgWriteData[0];
                    end
                    default: begin
                    end
                endcase
            end

            // Self clear wins over a write in the same cycle
            if (testDoneRise) begin
                Start <= 1'b0;
            end
        end
    end

    ////////////////////
    // Checks

    // A finished run must not be relaunched by a stale start bit
    startClearedAfterDone: assert property (
        @(posedge Clk) disable iff (!reset_n)
        $rose(TestDone) |=> !Start
    ) else $error("Start still set after TestDone rose");

endmodule

/* rtl/TrigTestPkg.sv */
package TrigTestPkg;

    ////////////////////
    // Widths

    localparam int CountWidth = 16;
    localparam int DelayWidth = 4;
    localparam int WordWidth = 16;
    localparam int CfgAddrWidth = 2;

    typedef logic [CountWidth-1:0]   countT;
    typedef logic [DelayWidth-1:0]   delayT;
    typedef logic [WordWidth-1:0]    wordT;
    typedef logic [CfgAddrWidth-1:0] cfgAddrT;

    ////////////////////
    // Register map

    localparam cfgAddrT CfgAddrCptMax = 2'd0;
    localparam cfgAddrT CfgAddrDelay = 2'd1;
    localparam cfgAddrT CfgAddrControl = 2'd2;

    ////////////////////
    // Frame layout

    localparam wordT FrameHeader = 16'h4343;
    localparam int NumChannels = 3;
    // Pulse and trigger count per channel
    localparam int FrameWords = 2 * NumChannels;
    localparam int WordCountWidth = $clog2(FrameWords + 1);

    ////////////////////
    // State machines

    typedef enum logic [2:0] {
        TsIdle, TsHeader, TsLaunch, TsMeasure, TsCapture, TsEmit, TsEmitStrobe, TsFinished
    } testStateT;

    typedef enum logic [1:0] {
        ScIdle, ScArmed, ScWindow, ScDone
    } scurveStateT;

endpackage
